/* rtl/bus_pkg.sv */
package bus_pkg;

    // Bus geometry
    localparam int NUM_DEVICES   = 8;
    localparam int DEV_IDX_WIDTH = 3;
    localparam int BUS_WIDTH     = 32;

    // Top address bits name the target device
    localparam int ADDR_SEL_LSB  = 29;

    // Control word field widths
    localparam int BURST_WIDTH   = 3;
    localparam int RSVD_WIDTH    = 3;

    // Control word carried on ctrl_in and ctrl_out
    typedef struct packed {
        logic [RSVD_WIDTH-1:0]  reserved;
        logic [BURST_WIDTH-1:0] burst;
        logic                   we;
        logic                   wait_flag;
    } bus_ctrl_t;

    // Transfer sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GRANT,
        ST_ADDR,
        ST_SLAVE_ACK,
        ST_BUSY,
        ST_FINISH
    } bus_state_e;

    // Owner of the routed bus word or ack
    typedef enum logic {
        SRC_MASTER,
        SRC_SLAVE
    } route_sel_e;

endpackage

/* rtl/req_arbiter.sv */
`timescale 1ns/10ps

module req_arbiter
    import bus_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [NUM_DEVICES-1:0]      req,
    input  logic                        arb_capture,
    input  bus_ctrl_t [NUM_DEVICES-1:0] ctrl_in,
    output logic [NUM_DEVICES-1:0]      grant,
    output logic                        we,
    output logic [BURST_WIDTH-1:0]      burst,
    output logic                        initiator_active
);

    logic [NUM_DEVICES-1:0] lowest_req;
    logic [1:0]             capture_dly;
    bus_ctrl_t              master_ctrl;

    // Isolate the lowest set request bit
    assign lowest_req = req & (~req + 1'b1);

    // Control word of the latched master
    always_comb begin
        master_ctrl = '0;
        for (int i = 0; i < NUM_DEVICES; i++) begin
            if (grant[i]) begin
                master_ctrl = master_ctrl | ctrl_in[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant       <= '0;
            capture_dly <= '0;
            we          <= 1'b0;
            burst       <= '0;
        end else begin
            capture_dly <= {capture_dly[0], arb_capture};
            if (arb_capture) begin
                grant <= lowest_req;
            end
            // Attributes are taken in the address phase, while the master drives them
            if (capture_dly[1]) begin
                we    <= master_ctrl.we;
                burst <= master_ctrl.burst;
            end
        end
    end

    // Master still holds its request
    assign initiator_active = |(req & grant);

endmodule

/* rtl/addr_translator.sv */
`timescale 1ns/10ps

module addr_translator
    import bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [BUS_WIDTH-1:0]   virt_addr,
    input  logic                   slave_capture,
    input  logic                   slave_clear,
    output logic [BUS_WIDTH-1:0]   phys_addr,
    output logic [NUM_DEVICES-1:0] slave_sel
);

    logic [DEV_IDX_WIDTH-1:0] dev_idx;
    logic [NUM_DEVICES-1:0]   dev_onehot;

    assign dev_idx = virt_addr[ADDR_SEL_LSB +: DEV_IDX_WIDTH];

    // Strip the device field, keep the offset inside the device
    always_comb begin
        phys_addr = virt_addr;
        phys_addr[ADDR_SEL_LSB +: DEV_IDX_WIDTH] = '0;
    end

    always_comb begin
        dev_onehot          = '0;
        dev_onehot[dev_idx] = 1'b1;
    end

    // Clear wins over capture
    always_ff @(posedge clk) begin
        if (reset || slave_clear) begin
            slave_sel <= '0;
        end else if (slave_capture) begin
            slave_sel <= dev_onehot;
        end
    end

endmodule

/* rtl/bus_router.sv */
`timescale 1ns/10ps

module bus_router
    import bus_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [NUM_DEVICES-1:0][BUS_WIDTH-1:0]  bus_in,
    input  bus_ctrl_t [NUM_DEVICES-1:0]            ctrl_in,
    input  logic [NUM_DEVICES-1:0]                 grant,
    input  logic [NUM_DEVICES-1:0]                 slave_sel,
    input  route_sel_e                             ack_src,
    input  route_sel_e                             data_src,
    input  logic                                   ack_en,
    input  logic                                   addr_phase,
    input  logic                                   hold_addr,
    input  logic                                   force_ctrl,
    input  logic                                   we,
    input  logic [BURST_WIDTH-1:0]                 burst,
    input  logic [BUS_WIDTH-1:0]                   phys_addr,
    output logic [BUS_WIDTH-1:0]                   sel_word,
    output logic [NUM_DEVICES-1:0]                 ack,
    output logic [BUS_WIDTH-1:0]                   bus_out,
    output bus_ctrl_t                              ctrl_out
);

    logic [NUM_DEVICES-1:0] data_sel;
    logic [BUS_WIDTH-1:0]   prev_bus;
    bus_ctrl_t              routed_ctrl;

    always_comb begin
        if (!ack_en) begin
            ack = '0;
        end else if (ack_src == SRC_SLAVE) begin
            ack = slave_sel;
        end else begin
            ack = grant;
        end
    end

    assign data_sel = (data_src == SRC_SLAVE) ? slave_sel : grant;

    // One-hot AND-OR muxes; the control word follows the acked device
    always_comb begin
        sel_word    = '0;
        routed_ctrl = '0;
        for (int i = 0; i < NUM_DEVICES; i++) begin
            if (data_sel[i]) begin
                sel_word = sel_word | bus_in[i];
            end
            if (ack[i]) begin
                routed_ctrl = routed_ctrl | ctrl_in[i];
            end
        end
    end

    // Replay keeps the address on the bus while the slave is first acked
    always_comb begin
        if (hold_addr) begin
            bus_out = prev_bus;
        end else if (addr_phase) begin
            bus_out = phys_addr;
        end else begin
            bus_out = sel_word;
        end
    end

    always_comb begin
        if (force_ctrl) begin
            ctrl_out           = '0;
            ctrl_out.burst     = burst;
            ctrl_out.we        = we;
            ctrl_out.wait_flag = 1'b1;
        end else begin
            ctrl_out = routed_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_bus <= '0;
        end else begin
            prev_bus <= bus_out;
        end
    end

endmodule

/* rtl/bus_sequencer.sv */
`timescale 1ns/10ps

module bus_sequencer
    import bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [NUM_DEVICES-1:0] req,
    input  logic                   initiator_active,
    input  logic                   we,
    output bus_state_e             state,
    output logic                   arb_capture,
    output logic                   slave_capture,
    output logic                   slave_clear,
    output route_sel_e             ack_src,
    output route_sel_e             data_src,
    output logic                   ack_en,
    output logic                   addr_phase,
    output logic                   hold_addr,
    output logic                   force_ctrl
);

    bus_state_e next_state;
    route_sel_e xfer_src;

    // Write data comes from the master, read data from the slave
    assign xfer_src = we ? SRC_MASTER : SRC_SLAVE;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (req != '0) begin
                    next_state = ST_GRANT;
                end
            end
            ST_GRANT:     next_state = ST_ADDR;
            ST_ADDR:      next_state = ST_SLAVE_ACK;
            ST_SLAVE_ACK: next_state = ST_BUSY;
            ST_BUSY: begin
                // Master ends the transfer by dropping its request
                if (!initiator_active) begin
                    next_state = ST_FINISH;
                end
            end
            ST_FINISH:    next_state = ST_IDLE;
            default:      next_state = ST_IDLE;
        endcase
    end

    always_comb begin
        arb_capture   = 1'b0;
        slave_capture = 1'b0;
        slave_clear   = 1'b0;
        ack_src       = SRC_MASTER;
        data_src      = SRC_MASTER;
        ack_en        = 1'b0;
        addr_phase    = 1'b0;
        hold_addr     = 1'b0;
        force_ctrl    = 1'b0;
        case (state)
            ST_IDLE: begin
                arb_capture = (req != '0);
            end
            ST_GRANT: begin
                ack_en = 1'b1;
            end
            ST_ADDR: begin
                ack_en        = 1'b1;
                addr_phase    = 1'b1;
                slave_capture = 1'b1;
            end
            ST_SLAVE_ACK: begin
                ack_en     = 1'b1;
                ack_src    = SRC_SLAVE;
                hold_addr  = 1'b1;
                force_ctrl = 1'b1;
            end
            ST_BUSY: begin
                ack_en   = 1'b1;
                ack_src  = SRC_SLAVE;
                data_src = xfer_src;
            end
            ST_FINISH: begin
                data_src    = xfer_src;
                slave_clear = 1'b1;
            end
            default: begin
                slave_clear = 1'b1;
            end
        endcase
    end

endmodule

/* rtl/bus_controller.sv */
`timescale 1ns/10ps

module bus_controller
    import bus_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [NUM_DEVICES-1:0]                req,
    input  bus_ctrl_t [NUM_DEVICES-1:0]           ctrl_in,
    input  logic [NUM_DEVICES-1:0][BUS_WIDTH-1:0] bus_in,
    output logic [NUM_DEVICES-1:0]                ack,
    output bus_ctrl_t                             ctrl_out,
    output logic [BUS_WIDTH-1:0]                  bus_out
);

    logic [NUM_DEVICES-1:0] grant;
    logic [NUM_DEVICES-1:0] slave_sel;
    logic                   we;
    logic [BURST_WIDTH-1:0] burst;
    logic                   initiator_active;
    logic [BUS_WIDTH-1:0]   sel_word;
    logic [BUS_WIDTH-1:0]   phys_addr;
    logic                   arb_capture;
    logic                   slave_capture;
    logic                   slave_clear;
    route_sel_e             ack_src;
    route_sel_e             data_src;
    logic                   ack_en;
    logic                   addr_phase;
    logic                   hold_addr;
    logic                   force_ctrl;

    req_arbiter arbiter_i (
        .clk              (clk),
        .reset            (reset),
        .req              (req),
        .arb_capture      (arb_capture),
        .ctrl_in          (ctrl_in),
        .grant            (grant),
        .we               (we),
        .burst            (burst),
        .initiator_active (initiator_active)
    );

    addr_translator translator_i (
        .clk           (clk),
        .reset         (reset),
        .virt_addr     (sel_word),
        .slave_capture (slave_capture),
        .slave_clear   (slave_clear),
        .phys_addr     (phys_addr),
        .slave_sel     (slave_sel)
    );

    bus_router router_i (
        .clk        (clk),
        .reset      (reset),
        .bus_in     (bus_in),
        .ctrl_in    (ctrl_in),
        .grant      (grant),
        .slave_sel  (slave_sel),
        .ack_src    (ack_src),
        .data_src   (data_src),
        .ack_en     (ack_en),
        .addr_phase (addr_phase),
        .hold_addr  (hold_addr),
        .force_ctrl (force_ctrl),
        .we         (we),
        .burst      (burst),
        .phys_addr  (phys_addr),
        .sel_word   (sel_word),
        .ack        (ack),
        .bus_out    (bus_out),
        .ctrl_out   (ctrl_out)
    );

    bus_sequencer sequencer_i (
        .clk              (clk),
        .reset            (reset),
        .req              (req),
        .initiator_active (initiator_active),
        .we               (we),
        .state            (),
        .arb_capture      (arb_capture),
        .slave_capture    (slave_capture),
        .slave_clear      (slave_clear),
        .ack_src          (ack_src),
        .data_src         (data_src),
        .ack_en           (ack_en),
        .addr_phase       (addr_phase),
        .hold_addr        (hold_addr),
        .force_ctrl       (force_ctrl)
    );

endmodule

/* tb/bus_controller_properties.sv */
`timescale 1ns/10ps

module bus_controller_properties
    import bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  bus_state_e             state,
    input  logic [NUM_DEVICES-1:0] ack
);

    // No device is acked outside a transfer
    ack_zero_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_IDLE || state == ST_FINISH) |-> (ack == '0)
    ) else $error("ack is set in idle or finish state");

    ack_at_most_one: assert property (
        @(posedge clk) disable iff (reset) $onehot0(ack)
    ) else $error("more than one ack bit is set");

    // Grant, address and slave ack phases run back to back
    grant_then_addr: assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_GRANT) |=> (state == ST_ADDR)
    ) else $error("grant state is not followed by address state");

    addr_then_slave_ack: assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_ADDR) |=> (state == ST_SLAVE_ACK)
    ) else $error("address state is not followed by slave ack state");

endmodule

bind bus_controller bus_controller_properties props_i (
    .clk   (clk),
    .reset (reset),
    .state (sequencer_i.state),
    .ack   (ack)
);

/* tb/bus_controller_tb.sv */
`timescale 1ns/10ps

module bus_controller_tb
    import bus_pkg::*;
();

    logic                                  clk;
    logic                                  reset;
    logic [NUM_DEVICES-1:0]                req;
    bus_ctrl_t [NUM_DEVICES-1:0]           ctrl_in;
    logic [NUM_DEVICES-1:0][BUS_WIDTH-1:0] bus_in;
    logic [NUM_DEVICES-1:0]                ack;
    bus_ctrl_t                             ctrl_out;
    logic [BUS_WIDTH-1:0]                  bus_out;

    // Transfer the device models are playing
    int                   cur_master;
    int                   cur_slave;
    logic [BUS_WIDTH-1:0] cur_vaddr;
    logic [BUS_WIDTH-1:0] cur_wdata;
    logic [BUS_WIDTH-1:0] cur_rdata;
    bus_ctrl_t            cur_mctrl;
    bus_ctrl_t            cur_sctrl;
    logic [31:0]          rand_state = 32'd90246;

    bus_controller bus_controller_i (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .ctrl_in  (ctrl_in),
        .bus_in   (bus_in),
        .ack      (ack),
        .ctrl_out (ctrl_out),
        .bus_out  (bus_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // An acked master drives address and attributes, a requesting master
    // its write word, an acked slave its read word, and idle devices drive noise
    always @(posedge clk) begin
        logic [31:0] rnd;
        for (int d = 0; d < NUM_DEVICES; d++) begin
            rnd = next_rand();
            if (d == cur_master && ack[d]) begin
                bus_in[d]  <= cur_vaddr;
                ctrl_in[d] <= cur_mctrl;
            end else if (d == cur_master && req[d]) begin
                bus_in[d]  <= cur_wdata;
                ctrl_in[d] <= rnd[31:24];
            end else if (d == cur_slave && ack[d]) begin
                bus_in[d]  <= cur_rdata;
                ctrl_in[d] <= cur_sctrl;
            end else begin
                bus_in[d]  <= rnd;
                ctrl_in[d] <= rnd[31:24];
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %0s expected %h actual %h", what, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic run_transfer(input logic [8*32-1:0] name, input logic [7:0] mask,
                                input logic [31:0] vaddr, input logic we,
                                input logic [2:0] burst, input logic [31:0] wdata,
                                input logic [31:0] rdata, input int busy_len);
        logic [7:0]  next_req;
        logic [7:0]  master_bit;
        logic [7:0]  slave_bit;
        logic [31:0] phys;
        bus_ctrl_t   fctrl;
        int          waited;

        next_req = req | mask;
        cur_master = 0;
        for (int i = NUM_DEVICES - 1; i >= 0; i--) begin
            if (next_req[i]) begin
                cur_master = i;
            end
        end
        cur_slave  = int'(vaddr[31:29]);
        master_bit = 8'(1 << cur_master);
        slave_bit  = 8'(1 << cur_slave);
        phys       = {3'b000, vaddr[28:0]};
        cur_vaddr  = vaddr;
        cur_wdata  = wdata;
        cur_rdata  = rdata;
        cur_mctrl  = '{reserved: 3'b000, burst: burst, we: we, wait_flag: 1'b0};
        // Slave answers with a control word of its own
        cur_sctrl  = '{reserved: 3'b000, burst: ~burst, we: ~we, wait_flag: 1'b0};
        fctrl      = '{reserved: 3'b000, burst: burst, we: we, wait_flag: 1'b1};

        @(posedge clk);
        req <= next_req;

        waited = 0;
        @(negedge clk);
        while (ack == '0) begin
            if (waited == 20) begin
                $display("Timeout: no ack within 20 cycles in %0s", name);
                $display(">>> FAIL");
                $fatal(1, "Timeout");
            end
            waited++;
            @(negedge clk);
        end
        check_value($sformatf("%0s grant ack", name), 32'(master_bit), 32'(ack));

        // Address phase
        @(negedge clk);
        check_value($sformatf("%0s addr ack", name), 32'(master_bit), 32'(ack));
        check_value($sformatf("%0s addr bus_out", name), phys, bus_out);
        check_value($sformatf("%0s addr ctrl_out", name), {24'b0, cur_mctrl},
                    {24'b0, ctrl_out});

        // Slave ack phase
        @(negedge clk);
        check_value($sformatf("%0s slave ack", name), 32'(slave_bit), 32'(ack));
        check_value($sformatf("%0s slave bus_out", name), phys, bus_out);
        check_value($sformatf("%0s slave ctrl_out", name), {24'b0, fctrl},
                    {24'b0, ctrl_out});

        for (int i = 0; i < busy_len; i++) begin
            @(negedge clk);
            check_value($sformatf("%0s busy ack", name), 32'(slave_bit), 32'(ack));
            check_value($sformatf("%0s busy bus_out", name), we ? wdata : rdata, bus_out);
            check_value($sformatf("%0s busy ctrl_out", name), {24'b0, cur_sctrl},
                        {24'b0, ctrl_out});
        end

        // Master ends the transfer while other requesters stay pending
        @(posedge clk);
        req <= req & ~master_bit;
        @(negedge clk);
        @(negedge clk);
        check_value($sformatf("%0s release ack", name), 32'h0, 32'(ack));
    endtask

    initial begin
        int               fd;
        int               n_fields;
        int               n_vectors;
        logic [8*128-1:0] line;
        logic [8*32-1:0]  v_name;
        logic [7:0]       v_mask;
        logic [31:0]      v_vaddr;
        logic [31:0]      v_wdata;
        logic [31:0]      v_rdata;
        int               v_we;
        int               v_burst;
        int               v_busy;

        n_vectors  = 0;
        reset      <= 1'b1;
        req        <= '0;
        ctrl_in    <= '0;
        bus_in     <= '0;
        cur_master = 0;
        cur_slave  = 0;
        cur_vaddr  = '0;
        cur_wdata  = '0;
        cur_rdata  = '0;
        cur_mctrl  = '0;
        cur_sctrl  = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Bus stays quiet without requests
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value("idle ack", 32'h0, 32'(ack));
            check_value("idle ctrl_out", 32'h0, {24'b0, ctrl_out});
        end

        fd = $fopen("tb/bus_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tb/bus_vectors.txt");
            $display(">>> FAIL");
            $fatal(1, "Missing vectors");
        end
        while ($fgets(line, fd) != 0) begin
            n_fields = $sscanf(line, "%s %h %h %d %d %h %h %d", v_name, v_mask, v_vaddr,
                               v_we, v_burst, v_wdata, v_rdata, v_busy);
            // Comment and blank lines do not parse into eight fields
            if (n_fields == 8) begin
                run_transfer(v_name, v_mask, v_vaddr, v_we[0], 3'(v_burst), v_wdata,
                             v_rdata, v_busy);
                n_vectors++;
            end
        end
        $fclose(fd);

        if (n_vectors == 0) begin
            $display("No transfers were read from the vector file");
            $display(">>> FAIL");
            $fatal(1, "Empty vectors");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* list.f */
rtl/bus_pkg.sv
rtl/req_arbiter.sv
rtl/addr_translator.sv
rtl/bus_router.sv
rtl/bus_sequencer.sv
rtl/bus_controller.sv
tb/bus_controller_properties.sv
tb/bus_controller_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the bus controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module bus_controller_tb \
    -Mdir obj_dir \
    -f list.f

# Exit status of the simulation is the test result
./obj_dir/Vbus_controller_tb

/* tb/bus_vectors.txt */
# name req_mask(hex) virt_addr(hex) we burst wdata(hex) rdata(hex) busy_cycles
# req_mask is added to the requests still pending from earlier transfers
single_write    01 60001234 1 4 cafe0001 0bad0001 3
single_read     04 a0000040 0 2 11112222 deadbeef 2
lowest_of_three 2c e0000100 1 7 a5a5a5a5 5a5a5a5a 4
pending_three   00 20000008 0 1 01020304 c001d00d 1
pending_five    00 40000ff0 1 0 0badf00d 12345678 2
all_request     ff 800000f0 0 3 77777777 88888888 3
next_one        00 c0000010 1 5 13579bdf 2468ace0 2
late_high       80 0abc0000 0 6 fedcba98 76543210 1
next_three      00 e0001000 1 2 00ff00ff ff00ff00 5
next_four       00 3fffffff 0 4 aaaa5555 5555aaaa 2
next_five       00 60000004 1 1 31415926 27182818 1
next_six        00 12345678 0 0 0f0f0f0f f0f0f0f0 3
next_seven      00 87654321 1 7 deadc0de facefeed 2
last_single     40 ffffffff 0 3 11223344 55667788 1
